// File: build.f
logic/host_pkg.sv
logic/mem_pkg.sv
logic/command_decoder.sv
logic/memory_sequencer.sv
logic/volume_stepper.sv
logic/readback_mux.sv
logic/recorder_top.sv
tests/recorder_assert.sv
tests/recorder_tb.sv

// File: tests/recorder_tb.sv
module recorder_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned SLOT_WORDS = 8;
	localparam int unsigned VOLUME_RESET = 1;
	localparam int MEM_WORDS = 64;
	// Cycle limit for any wait
	localparam int LIMIT = 400;

	logic clk1;
	logic pb_reset;
	host_pkg::host_byte_t pb_port_id;
	host_pkg::host_byte_t pb_out_port;
	logic pb_write_strobe;
	host_pkg::host_byte_t pb_in_port;
	logic [2:0] buttons;
	mem_pkg::sample_t audio_in;
	mem_pkg::sample_t audio_out;
	logic playback;
	mem_pkg::volume_t volume_level;
	mem_pkg::addr_t ram_address;
	mem_pkg::sample_t ram_wdata;
	logic ram_write_enable;
	logic ram_read_request;
	logic ram_read_ack;
	mem_pkg::sample_t ram_rdata;
	logic ram_data_present;

	// Word memory model and its logs
	mem_pkg::sample_t mem [MEM_WORDS];
	mem_pkg::sample_t saved [MEM_WORDS];
	mem_pkg::sample_t play_log[$];
	mem_pkg::addr_t wr_addr_log[$];
	mem_pkg::sample_t wr_data_log[$];
	mem_pkg::sample_t wr_sample_log[$];
	int read_delay;
	bit feed_samples;

	int test_errors;
	int tests_run;
	int tests_failed;
	int assert_seen;

	recorder_top #(
		.SLOT_WORDS(SLOT_WORDS),
		.ADDR_W(26),
		.VOLUME_RESET(VOLUME_RESET)
	) dut (
		.clk1(clk1),
		.pb_reset(pb_reset),
		.pb_port_id(pb_port_id),
		.pb_out_port(pb_out_port),
		.pb_write_strobe(pb_write_strobe),
		.pb_in_port(pb_in_port),
		.buttons(buttons),
		.audio_in(audio_in),
		.audio_out(audio_out),
		.playback(playback),
		.volume_level(volume_level),
		.ram_address(ram_address),
		.ram_wdata(ram_wdata),
		.ram_write_enable(ram_write_enable),
		.ram_read_request(ram_read_request),
		.ram_read_ack(ram_read_ack),
		.ram_rdata(ram_rdata),
		.ram_data_present(ram_data_present)
	);

	initial begin
		clk1 = 1'b0;
		forever #4 clk1 = ~clk1;
	end

	////////////////////////////////////////////////////////////
	// Memory model, all on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk1) begin
		if (ram_write_enable) begin
			if (ram_address < MEM_WORDS) begin
				mem[ram_address] = ram_wdata;
			end
			// Record pass: log, then present the next sample
			if (feed_samples) begin
				wr_addr_log.push_back(ram_address);
				wr_data_log.push_back(ram_wdata);
				wr_sample_log.push_back(audio_in);
				audio_in = mem_pkg::sample_t'($urandom);
			end
		end
		if (ram_read_ack) begin
			play_log.push_back(audio_out);
			ram_data_present = 1'b0;
		end
		// New request drops any stale word
		if (ram_read_request) begin
			ram_data_present = 1'b0;
			read_delay = $urandom_range(4, 1);
		end else if (read_delay > 0) begin
			read_delay--;
			if (read_delay == 0) begin
				ram_data_present = 1'b1;
				ram_rdata = mem[ram_address];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Host bus tasks, entered on a falling edge
	////////////////////////////////////////////////////////////

	task automatic write_port(input host_pkg::host_byte_t port, input host_pkg::host_byte_t value);
		pb_port_id = port;
		pb_out_port = value;
		pb_write_strobe = 1'b1;
		@(negedge clk1);
		pb_write_strobe = 1'b0;
	endtask

	// Readback register fills on the rising edge between
	task automatic read_back(input host_pkg::host_byte_t port, output host_pkg::host_byte_t value);
		pb_port_id = port;
		@(negedge clk1);
		value = pb_in_port;
	endtask

	task automatic check_value(input string name, input int unsigned expected,
		input int unsigned actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic expect_port(input string name, input host_pkg::host_byte_t port,
		input host_pkg::host_byte_t expected);
		host_pkg::host_byte_t value;
		read_back(port, value);
		check_value(name, expected, value);
	endtask

	// Busy is bit 1 of the state port
	task automatic wait_busy(input logic level, input string what);
		host_pkg::host_byte_t value;
		int n;
		n = 0;
		do begin
			read_back(host_pkg::PORT_STATE, value);
			n++;
		end while ((value[1] !== level) && (n < LIMIT));
		if (value[1] !== level) begin
			$display("Timeout waiting for %s", what);
			test_errors++;
		end
	endtask

	task automatic wait_pass(input string what);
		wait_busy(1'b1, {what, " to start"});
		wait_busy(1'b0, {what, " to finish"});
	endtask

	// Result line, assertion failures included
	task automatic finish_test(input string name);
		int fresh;
		fresh = dut.assert_checks.error_count - assert_seen;
		assert_seen = dut.assert_checks.error_count;
		if (fresh > 0) begin
			$display("Assertion checks failed %0d times during %s", fresh, name);
			test_errors += fresh;
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %s passed", name);
		end else begin
			$display("Test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		int n;
		int strobes;
		void'($urandom(32'hd148_c871));
		pb_reset = 1'b1;
		pb_port_id = '0;
		pb_out_port = '0;
		pb_write_strobe = 1'b0;
		buttons = 3'b100;
		audio_in = mem_pkg::sample_t'($urandom);
		ram_rdata = '0;
		ram_data_present = 1'b0;
		read_delay = 0;
		feed_samples = 1'b0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		assert_seen = 0;
		// Fill pattern from the whole address
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = mem_pkg::sample_t'(i * 16'h0257) ^ 16'ha5c3;
		end
		repeat (4) @(posedge clk1);
		@(negedge clk1);
		pb_reset = 1'b0;

		expect_port("state after reset", host_pkg::PORT_STATE, 8'h00);
		expect_port("delete done after reset", host_pkg::PORT_DELETE_DONE, 8'h00);
		expect_port("volume after reset", host_pkg::PORT_VOLUME_LEVEL, VOLUME_RESET);
		expect_port("select button", host_pkg::PORT_SELECT, 8'h01);
		finish_test("reset");

		// Record slot 2, value 4 on the record port
		feed_samples = 1'b1;
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_RECORD);
		write_port(host_pkg::PORT_RECORD, 8'd4);
		write_port(host_pkg::PORT_RECORD, 8'd1);
		wait_pass("record pass");
		feed_samples = 1'b0;
		check_value("record word count", SLOT_WORDS, wr_addr_log.size());
		for (i = 0; i < wr_addr_log.size(); i++) begin
			check_value("record address", 2 * SLOT_WORDS + i, wr_addr_log[i]);
			check_value("record data", wr_sample_log[i], wr_data_log[i]);
		end
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_PLAY);
		write_port(host_pkg::PORT_SLOT, 8'd2);
		wait_pass("play pass");
		check_value("play word count", SLOT_WORDS, play_log.size());
		for (i = 0; (i < play_log.size()) && (i < wr_sample_log.size()); i++) begin
			check_value("play sample", wr_sample_log[i], play_log[i]);
		end
		expect_port("message exists", host_pkg::PORT_STATE, 8'h01);
		finish_test("record then play");

		saved = mem;
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_DELONE);
		write_port(host_pkg::PORT_SLOT, 8'd2);
		wait_pass("delete one pass");
		for (i = 0; i < 5 * SLOT_WORDS; i++) begin
			check_value("delete one word", (i / SLOT_WORDS == 2) ? 0 : saved[i], mem[i]);
		end
		expect_port("delete done", host_pkg::PORT_DELETE_DONE, 8'h01);
		finish_test("delete one");

		// Delete all starts on the mode write
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_DELALL);
		wait_pass("delete all pass");
		for (i = 0; i < 5 * SLOT_WORDS; i++) begin
			check_value("delete all word", 0, mem[i]);
		end
		finish_test("delete all");

		write_port(host_pkg::PORT_STATE, host_pkg::MODE_VOL);
		repeat (16) write_port(host_pkg::PORT_VOLUME, 8'd1);
		expect_port("volume at top", host_pkg::PORT_VOLUME_LEVEL, 8'd15);
		check_value("volume level output", 15, volume_level);
		// Steps ignored outside volume mode
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_MAIN);
		write_port(host_pkg::PORT_VOLUME, 8'd2);
		// Let a stray step reach the level before reading
		@(negedge clk1);
		expect_port("volume outside mode", host_pkg::PORT_VOLUME_LEVEL, 8'd15);
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_VOL);
		repeat (20) write_port(host_pkg::PORT_VOLUME, 8'd2);
		expect_port("volume at bottom", host_pkg::PORT_VOLUME_LEVEL, 8'd1);
		finish_test("volume");

		// Abort a playback after two words
		play_log.delete();
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_PLAY);
		write_port(host_pkg::PORT_SLOT, 8'd0);
		n = 0;
		while ((play_log.size() < 2) && (n < LIMIT)) begin
			@(posedge clk1);
			n++;
		end
		@(negedge clk1);
		if (play_log.size() < 2) begin
			$display("Timeout waiting for playback to start");
			test_errors++;
		end
		check_value("playback while playing", 1, playback);
		write_port(host_pkg::PORT_STATE, host_pkg::MODE_MAIN);
		@(negedge clk1);
		strobes = 0;
		for (i = 0; i < 8; i++) begin
			strobes += ram_write_enable + ram_read_request + ram_read_ack;
			@(negedge clk1);
		end
		check_value("strobes after abort", 0, strobes);
		check_value("playback after abort", 0, playback);
		expect_port("busy after abort", host_pkg::PORT_STATE, 8'h00);
		finish_test("abort");

		$display("Tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, assert_seen);
		if (tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: tests/recorder_assert.sv
module recorder_assert #(
	parameter int unsigned SLOT_WORDS = 16
) (
	input logic clk1,
	input logic pb_reset,
	input mem_pkg::addr_t ram_address,
	input mem_pkg::sample_t ram_wdata,
	input logic ram_write_enable,
	input logic ram_read_request,
	input logic ram_read_ack,
	input logic ram_data_present,
	input logic playback,
	input mem_pkg::volume_t volume_level,
	// Sequencer internals
	input mem_pkg::addr_t last_addr,
	input logic del_pass,
	input logic all_pass,
	input logic busy
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench
	int error_count = 0;
	// Read issued, no ack yet
	logic read_pending;

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			read_pending <= 1'b0;
		end else if (ram_read_request) begin
			read_pending <= 1'b1;
		end else if (ram_read_ack) begin
			read_pending <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory port rules
	////////////////////////////////////////////////////////////

	// Nothing moves while reset holds
	reset_quiet: assert property (@(posedge clk1)
		pb_reset |-> !(ram_write_enable || ram_read_request || ram_read_ack || playback || busy))
	else begin
		$error("Control outputs active during reset");
		error_count++;
	end

	// Slot pass spans SLOT_WORDS words ending at last_addr
	write_in_pass: assert property (@(posedge clk1) disable iff (pb_reset)
		ram_write_enable |-> (ram_address <= last_addr) &&
			(all_pass || (ram_address + SLOT_WORDS > last_addr)))
	else begin
		$error("Write address %0h outside the pass", ram_address);
		error_count++;
	end

	delete_zero: assert property (@(posedge clk1) disable iff (pb_reset)
		(ram_write_enable && del_pass) |-> (ram_wdata == '0))
	else begin
		$error("Delete wrote nonzero data %0h", ram_wdata);
		error_count++;
	end

	// Ack only after data seen on an open read
	ack_after_data: assert property (@(posedge clk1) disable iff (pb_reset)
		$rose(ram_read_ack) |-> $past(ram_data_present && read_pending))
	else begin
		$error("Read ack without data present");
		error_count++;
	end

	// Zero is the only four-bit value below the range
	volume_range: assert property (@(posedge clk1) disable iff (pb_reset)
		(volume_level >= 4'd1))
	else begin
		$error("Volume %0d out of range", volume_level);
		error_count++;
	end

endmodule

bind recorder_top recorder_assert #(
	.SLOT_WORDS(SLOT_WORDS)
) assert_checks (
	.clk1(clk1),
	.pb_reset(pb_reset),
	.ram_address(ram_address),
	.ram_wdata(ram_wdata),
	.ram_write_enable(ram_write_enable),
	.ram_read_request(ram_read_request),
	.ram_read_ack(ram_read_ack),
	.ram_data_present(ram_data_present),
	.playback(playback),
	.volume_level(volume_level),
	.last_addr(sequencer.last_addr),
	.del_pass(sequencer.del_pass),
	.all_pass(sequencer.all_pass),
	.busy(status.busy)
);

// File: logic/recorder_top.sv
module recorder_top #(
	parameter int unsigned SLOT_WORDS = 16,
	parameter int unsigned ADDR_W = 26,
	parameter int unsigned VOLUME_RESET = 1
) (
	input logic clk1,
	input logic pb_reset,
	// Processor bus
	input host_pkg::host_byte_t pb_port_id,
	input host_pkg::host_byte_t pb_out_port,
	input logic pb_write_strobe,
	output host_pkg::host_byte_t pb_in_port,
	// Front panel and audio
	input logic [2:0] buttons,
	input mem_pkg::sample_t audio_in,
	output mem_pkg::sample_t audio_out,
	output logic playback,
	output mem_pkg::volume_t volume_level,
	// Word memory port
	output mem_pkg::addr_t ram_address,
	output mem_pkg::sample_t ram_wdata,
	output logic ram_write_enable,
	output logic ram_read_request,
	output logic ram_read_ack,
	input mem_pkg::sample_t ram_rdata,
	input logic ram_data_present
);

	host_pkg::command_t command;
	mem_pkg::mem_req_t mem_req;
	mem_pkg::seq_status_t status;
	mem_pkg::volume_t volume;

	// Host writes to commands
	command_decoder decoder (
		.clk1(clk1),
		.pb_reset(pb_reset),
		.pb_port_id(pb_port_id),
		.pb_out_port(pb_out_port),
		.pb_write_strobe(pb_write_strobe),
		.busy(status.busy),
		.command(command)
	);

	// Play, record and delete passes
	memory_sequencer #(
		.SLOT_WORDS(SLOT_WORDS),
		.ADDR_W(ADDR_W)
	) sequencer (
		.clk1(clk1),
		.pb_reset(pb_reset),
		.command(command),
		.audio_in(audio_in),
		.ram_rdata(ram_rdata),
		.ram_data_present(ram_data_present),
		.mem_req(mem_req),
		.audio_out(audio_out),
		.playback(playback),
		.status(status)
	);

	// Volume level beside the sequencer
	volume_stepper #(
		.VOLUME_RESET(VOLUME_RESET)
	) stepper (
		.clk1(clk1),
		.pb_reset(pb_reset),
		.vol_up(command.vol_up),
		.vol_down(command.vol_down),
		.level(volume)
	);

	// Host reads
	readback_mux readback (
		.clk1(clk1),
		.pb_reset(pb_reset),
		.pb_port_id(pb_port_id),
		.buttons(buttons),
		.status(status),
		.volume(volume),
		.pb_in_port(pb_in_port)
	);

	// Memory request fields to pins
	assign ram_address = mem_req.address;
	assign ram_wdata = mem_req.wdata;
	assign ram_write_enable = mem_req.write_enable;
	assign ram_read_request = mem_req.read_request;
	assign ram_read_ack = mem_req.read_ack;
	assign volume_level = volume;

endmodule

// File: logic/readback_mux.sv
module readback_mux (
	input logic clk1,
	input logic pb_reset,
	input host_pkg::host_byte_t pb_port_id,
	// select, back, pause_play from high to low
	input logic [2:0] buttons,
	input mem_pkg::seq_status_t status,
	input mem_pkg::volume_t volume,
	output host_pkg::host_byte_t pb_in_port
);

	// State port byte
	// bit 0 message exists, bit 1 pass running
	host_pkg::host_byte_t state_byte;

	assign state_byte = {6'b0, status.busy, status.message_exists};

	// One cycle read latency, unknown ports read zero
	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			pb_in_port <= '0;
		end else begin
			case (pb_port_id)
				host_pkg::PORT_SELECT: pb_in_port <= host_pkg::host_byte_t'(buttons[2]);
				host_pkg::PORT_BACK: pb_in_port <= host_pkg::host_byte_t'(buttons[1]);
				host_pkg::PORT_PAUSE: pb_in_port <= host_pkg::host_byte_t'(buttons[0]);
				host_pkg::PORT_STATE: pb_in_port <= state_byte;
				host_pkg::PORT_DELETE_DONE: begin
					pb_in_port <= host_pkg::host_byte_t'(status.delete_finish);
				end
				host_pkg::PORT_VOLUME_LEVEL: pb_in_port <= host_pkg::host_byte_t'(volume);
				default: pb_in_port <= '0;
			endcase
		end
	end

endmodule

// File: logic/volume_stepper.sv
module volume_stepper #(
	parameter int unsigned VOLUME_RESET = 1
) (
	input logic clk1,
	input logic pb_reset,
	input logic vol_up,
	input logic vol_down,
	output mem_pkg::volume_t level
);

	// Limits reached, step ignored
	logic at_max;
	logic at_min;

	assign at_max = (level >= mem_pkg::VOLUME_MAX);
	assign at_min = (level <= mem_pkg::VOLUME_MIN);

	// Saturating counter, one step per pulse
	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			level <= mem_pkg::volume_t'(VOLUME_RESET);
		end else if (vol_up && !at_max) begin
			level <= level + 1'b1;
		end else if (vol_down && !at_min) begin
			level <= level - 1'b1;
		end
	end

endmodule

// File: logic/memory_sequencer.sv
module memory_sequencer #(
	parameter int unsigned SLOT_WORDS = 16,
	parameter int unsigned ADDR_W = 26
) (
	input logic clk1,
	input logic pb_reset,
	input host_pkg::command_t command,
	input mem_pkg::sample_t audio_in,
	input mem_pkg::sample_t ram_rdata,
	input logic ram_data_present,
	output mem_pkg::mem_req_t mem_req,
	output mem_pkg::sample_t audio_out,
	output logic playback,
	output mem_pkg::seq_status_t status
);

	// Slot geometry
	localparam logic [ADDR_W-1:0] SLOT_SPAN = ADDR_W'(SLOT_WORDS);
	localparam logic [ADDR_W-1:0] ALL_LAST = ADDR_W'(host_pkg::NUM_SLOTS * SLOT_WORDS - 1);

	mem_pkg::seq_state_e state;

	// Pass address and its upper bound
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] last_addr;
	logic [ADDR_W-1:0] slot_base;

	// Kind of write pass
	logic rec_pass;
	logic del_pass;
	logic all_pass;

	// Pass end conditions
	logic at_last;
	logic rec_stopped;

	// Host flags
	logic message_exists;
	logic delete_finish;

	assign slot_base = ADDR_W'(command.slot) * SLOT_SPAN;
	assign at_last = (addr == last_addr);
	// recording dropped by the host ends a record pass early
	assign rec_stopped = rec_pass && !command.recording;

	////////////////////////////////////////////////////////////
	// Pass control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			state <= mem_pkg::IDLE;
			addr <= '0;
			last_addr <= '0;
			rec_pass <= 1'b0;
			del_pass <= 1'b0;
			all_pass <= 1'b0;
			playback <= 1'b0;
			message_exists <= 1'b0;
			delete_finish <= 1'b0;
		end else if (command.start) begin
			// New pass, bounds taken from the mode
			delete_finish <= 1'b0;
			addr <= slot_base;
			last_addr <= slot_base + SLOT_SPAN - 1'b1;
			rec_pass <= (command.mode == host_pkg::MODE_RECORD);
			del_pass <= (command.mode == host_pkg::MODE_DELONE) ||
				(command.mode == host_pkg::MODE_DELALL);
			all_pass <= (command.mode == host_pkg::MODE_DELALL);
			playback <= (command.mode == host_pkg::MODE_PLAY);
			case (command.mode)
				host_pkg::MODE_PLAY: state <= mem_pkg::READ_REQ;
				host_pkg::MODE_RECORD: state <= mem_pkg::WRITE_WORD;
				host_pkg::MODE_DELONE: state <= mem_pkg::WRITE_WORD;
				host_pkg::MODE_DELALL: begin
					// Whole slot area from word zero
					addr <= '0;
					last_addr <= ALL_LAST;
					state <= mem_pkg::WRITE_WORD;
				end
				default: state <= mem_pkg::IDLE;
			endcase
		end else if (command.abort) begin
			// Drop the pass, strobes go low next cycle
			state <= mem_pkg::IDLE;
			playback <= 1'b0;
		end else begin
			case (state)
				mem_pkg::WRITE_WORD: begin
					// Write strobe is up this cycle
					if (rec_pass) begin
						message_exists <= 1'b1;
					end
					state <= mem_pkg::ADVANCE_WRITE;
				end
				mem_pkg::ADVANCE_WRITE: begin
					if (at_last || rec_stopped) begin
						state <= mem_pkg::IDLE;
						delete_finish <= del_pass;
						// Nothing left after a full wipe
						if (all_pass) begin
							message_exists <= 1'b0;
						end
					end else begin
						addr <= addr + 1'b1;
						state <= mem_pkg::WRITE_WORD;
					end
				end
				mem_pkg::READ_REQ: begin
					state <= mem_pkg::READ_WAIT;
				end
				mem_pkg::READ_WAIT: begin
					// Stall until the memory has the word
					if (ram_data_present) begin
						state <= mem_pkg::ADVANCE_READ;
					end
				end
				mem_pkg::ADVANCE_READ: begin
					if (at_last) begin
						state <= mem_pkg::IDLE;
						playback <= 1'b0;
					end else begin
						addr <= addr + 1'b1;
						state <= mem_pkg::READ_REQ;
					end
				end
				default: state <= mem_pkg::IDLE;
			endcase
		end
	end

	// Sample out, held between reads
	always_ff @(posedge clk1) begin
		if ((state == mem_pkg::READ_WAIT) && ram_data_present) begin
			audio_out <= ram_rdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory strobes, decoded from state
	////////////////////////////////////////////////////////////

	always_comb begin
		mem_req.address = mem_pkg::addr_t'(addr);
		// Record stores the live sample, delete stores zero
		mem_req.wdata = rec_pass ? audio_in : '0;
		mem_req.write_enable = (state == mem_pkg::WRITE_WORD);
		mem_req.read_request = (state == mem_pkg::READ_REQ);
		// Ack follows the data present cycle
		mem_req.read_ack = (state == mem_pkg::ADVANCE_READ);
	end

	assign status.message_exists = message_exists;
	assign status.delete_finish = delete_finish;
	assign status.busy = (state != mem_pkg::IDLE);

endmodule

// File: logic/command_decoder.sv
module command_decoder (
	input logic clk1,
	input logic pb_reset,
	input host_pkg::host_byte_t pb_port_id,
	input host_pkg::host_byte_t pb_out_port,
	input logic pb_write_strobe,
	input logic busy,
	output host_pkg::command_t command
);

	// Port write qualifiers
	logic wr_state;
	logic wr_slot;
	logic wr_record;
	logic wr_volume;

	// Value checks on the written byte
	logic mode_legal;
	logic slot_legal;
	logic rec_slot_sel;
	logic rec_go;

	assign wr_state = pb_write_strobe && (pb_port_id == host_pkg::PORT_STATE);
	assign wr_slot = pb_write_strobe && (pb_port_id == host_pkg::PORT_SLOT);
	assign wr_record = pb_write_strobe && (pb_port_id == host_pkg::PORT_RECORD);
	assign wr_volume = pb_write_strobe && (pb_port_id == host_pkg::PORT_VOLUME);

	// Modes 0 to 5 only
	assign mode_legal = pb_out_port <= host_pkg::host_byte_t'(host_pkg::MODE_VOL);
	// Slots 0 to 4
	assign slot_legal = pb_out_port < host_pkg::host_byte_t'(host_pkg::NUM_SLOTS);
	// Record port, 2 to 6 picks a slot and 1 starts recording
	assign rec_slot_sel = (pb_out_port >= 8'd2) && (pb_out_port <= 8'd6);
	assign rec_go = (pb_out_port == 8'd1);

	////////////////////////////////////////////////////////////
	// Command register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			// Mode MAIN encodes as zero
			command <= '0;
		end else begin
			// Pulses last one cycle
			command.start <= 1'b0;
			command.abort <= 1'b0;
			command.vol_up <= 1'b0;
			command.vol_down <= 1'b0;

			// New menu mode
			if (wr_state && mode_legal) begin
				command.mode <= host_pkg::mode_e'(pb_out_port[2:0]);
				// Stop whatever pass is running
				command.abort <= busy;
				// Delete all needs no slot, so it starts here
				command.start <= (pb_out_port[2:0] == host_pkg::MODE_DELALL);
				command.recording <= 1'b0;
			end

			// Slot pick, starts a pass in play and delete-one
			if (wr_slot && slot_legal) begin
				command.slot <= host_pkg::slot_t'(pb_out_port);
				command.start <= (command.mode == host_pkg::MODE_PLAY) ||
					(command.mode == host_pkg::MODE_DELONE);
			end

			// Record control
			if (wr_record && (command.mode == host_pkg::MODE_RECORD)) begin
				if (rec_slot_sel) begin
					command.slot <= host_pkg::slot_t'(pb_out_port - 8'd2);
					command.recording <= 1'b0;
				end else if (rec_go) begin
					command.recording <= 1'b1;
					command.start <= 1'b1;
				end
			end

			// Volume steps
			if (wr_volume && (command.mode == host_pkg::MODE_VOL)) begin
				command.vol_up <= (pb_out_port == 8'd1);
				command.vol_down <= (pb_out_port == 8'd2);
			end
		end
	end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////////////////////////
	// Word memory side of the recorder
	////////////////////////////////////////////////////////////

	// Full memory address as seen on the port
	localparam int ADDR_BITS = 26;
	typedef logic [ADDR_BITS-1:0] addr_t;

	// One audio sample per memory word
	typedef logic [15:0] sample_t;

	// Volume level and its limits
	typedef logic [3:0] volume_t;
	localparam volume_t VOLUME_MIN = 4'd1;
	localparam volume_t VOLUME_MAX = 4'd15;

	// Request bundle toward the memory
	typedef struct packed {
		addr_t address;
		sample_t wdata;
		logic write_enable;
		logic read_request;
		logic read_ack;
	} mem_req_t;

	// Sequencer flags for host readback
	typedef struct packed {
		logic message_exists;
		logic delete_finish;
		logic busy;
	} seq_status_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		IDLE,
		WRITE_WORD,
		ADVANCE_WRITE,
		READ_REQ,
		READ_WAIT,
		ADVANCE_READ
	} seq_state_e;

endpackage

// File: logic/host_pkg.sv
package host_pkg;

	////////////////////////////////////////////////////////////
	// Host side of the recorder
	////////////////////////////////////////////////////////////

	// One byte on the processor bus, data or port number
	typedef logic [7:0] host_byte_t;

	// Writable ports
	localparam host_byte_t PORT_VOLUME = 8'h04;
	localparam host_byte_t PORT_RECORD = 8'h05;
	// Mode on write, message exists on read
	localparam host_byte_t PORT_STATE = 8'h0B;
	localparam host_byte_t PORT_SLOT = 8'h0C;

	// Read-only ports
	localparam host_byte_t PORT_SELECT = 8'h08;
	localparam host_byte_t PORT_BACK = 8'h09;
	localparam host_byte_t PORT_PAUSE = 8'h0A;
	localparam host_byte_t PORT_DELETE_DONE = 8'h0F;
	localparam host_byte_t PORT_VOLUME_LEVEL = 8'h10;

	// Message slots in memory
	localparam int NUM_SLOTS = 5;
	typedef logic [2:0] slot_t;

	// Menu mode, coded as the host writes it
	typedef enum logic [2:0] {
		MODE_MAIN = 3'd0,
		MODE_PLAY = 3'd1,
		MODE_RECORD = 3'd2,
		MODE_DELONE = 3'd3,
		MODE_DELALL = 3'd4,
		MODE_VOL = 3'd5
	} mode_e;

	// Decoded command, 11 bits
	// start, abort and volume steps are single-cycle pulses
	typedef struct packed {
		mode_e mode;
		slot_t slot;
		logic start;
		logic abort;
		logic recording;
		logic vol_up;
		logic vol_down;
	} command_t;

endpackage
